/* hdl/gpr_bank.sv */
`timescale 1ns/1ns
`include "rf_consts.svh"

module gpr_bank (
    input  logic                   clk,
    input  logic                   reset,
    gpr_write_if.sink              wr,
    output rf_data_pkg::reg_data_t regs [`RF_NUM_REGS]
);

    logic [7:0]                  low_q   [`RF_NUM_REGS];
    logic [7:0]                  high_q  [`RF_NUM_REGS];
    logic [`RF_DATA_WIDTH-1:16]  upper_q [`RF_NUM_REGS];

    rf_data_pkg::section_sel_t wr_sel;
    logic [7:0]                high_in;

    assign wr_sel = rf_data_pkg::section_mask(wr.addr, wr.size);

    // A byte write always carries its value in the lowest byte of data
    assign high_in = (wr.size == rf_data_pkg::size_byte) ? wr.data[7:0] : wr.data[15:8];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RF_NUM_REGS; i++) begin
                low_q[i]   <= '0;
                high_q[i]  <= '0;
                upper_q[i] <= '0;
            end
        end else if (wr.en) begin
            if (wr_sel.mask[0]) begin
                low_q[wr_sel.idx] <= wr.data[7:0];
            end
            if (wr_sel.mask[1]) begin
                high_q[wr_sel.idx] <= high_in;
            end
            if (wr_sel.mask[2]) begin
                upper_q[wr_sel.idx] <= wr.data[`RF_DATA_WIDTH-1:16];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `RF_NUM_REGS; i++) begin
            regs[i] = {upper_q[i], high_q[i], low_q[i]};
        end
    end

    // The write source must never enable a write that covers no section
    write_size_valid: assert property (
        @(posedge clk) disable iff (reset)
        wr.en |-> (wr.size != rf_data_pkg::size_none)
    );

endmodule

/* hdl/gpr_read_format.sv */
`timescale 1ns/1ns
`include "rf_consts.svh"

module gpr_read_format (
    input  rf_data_pkg::reg_data_t    regs [`RF_NUM_REGS],
    input  rf_data_pkg::reg_addr_t    rd_addr,
    input  rf_data_pkg::access_size_t rd_size,
    output rf_data_pkg::reg_data_t    rd_data
);

    rf_data_pkg::section_sel_t rd_sel;
    rf_data_pkg::reg_data_t    reg_val;
    logic [7:0]                byte_val;

    assign rd_sel  = rf_data_pkg::section_mask(rd_addr, rd_size);
    assign reg_val = regs[rd_sel.idx];

    // In byte mode the mask names either the low or the high byte
    assign byte_val = rd_sel.mask[1] ? reg_val[15:8] : reg_val[7:0];

    always_comb begin
        case (rd_size)
            rf_data_pkg::size_byte: begin
                rd_data = {{(`RF_DATA_WIDTH-8){byte_val[7]}}, byte_val};
            end
            rf_data_pkg::size_word: begin
                rd_data = {{(`RF_DATA_WIDTH-16){reg_val[15]}}, reg_val[15:0]};
            end
            rf_data_pkg::size_dword: begin
                rd_data = reg_val;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

/* hdl/regfile_top.sv */
`timescale 1ns/1ns
`include "rf_consts.svh"

module regfile_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_en,
    input  rf_data_pkg::reg_addr_t    wr_addr,
    input  rf_data_pkg::access_size_t wr_size,
    input  rf_data_pkg::reg_data_t    wr_data,
    input  logic                      claim_en,
    input  rf_data_pkg::reg_addr_t    claim_addr,
    input  rf_data_pkg::access_size_t claim_size,
    input  rf_tag_pkg::tag_t          claim_tag,
    input  logic                      broadcast_en,
    input  rf_tag_pkg::tag_t          broadcast_tag,
    input  logic                      flush,
    input  rf_data_pkg::reg_addr_t    rd_addr,
    input  rf_data_pkg::access_size_t rd_size,
    output rf_data_pkg::reg_data_t    rd_data,
    output logic                      rd_busy,
    output rf_tag_pkg::tag_t          rd_tag
);

    gpr_write_if wr_bus ();
    tag_claim_if claim_bus ();

    rf_data_pkg::reg_data_t regs [`RF_NUM_REGS];

    assign wr_bus.en   = wr_en;
    assign wr_bus.addr = wr_addr;
    assign wr_bus.size = wr_size;
    assign wr_bus.data = wr_data;

    assign claim_bus.en   = claim_en;
    assign claim_bus.addr = claim_addr;
    assign claim_bus.size = claim_size;
    assign claim_bus.tag  = claim_tag;

    gpr_bank bank (
        .clk   (clk),
        .reset (reset),
        .wr    (wr_bus.sink),
        .regs  (regs)
    );

    gpr_read_format read_fmt (
        .regs    (regs),
        .rd_addr (rd_addr),
        .rd_size (rd_size),
        .rd_data (rd_data)
    );

    tag_tracker tracker (
        .clk           (clk),
        .reset         (reset),
        .claim         (claim_bus.sink),
        .broadcast_en  (broadcast_en),
        .broadcast_tag (broadcast_tag),
        .flush         (flush),
        .rd_addr       (rd_addr),
        .rd_size       (rd_size),
        .rd_busy       (rd_busy),
        .rd_tag        (rd_tag)
    );

endmodule

/* hdl/rf_consts.svh */
`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// Eight general registers, as in the x86 integer set
`define RF_NUM_REGS 8

`define RF_DATA_WIDTH 32

// Producer tags name an in-flight result
`define RF_TAG_WIDTH 7

`define RF_ADDR_WIDTH 3

`endif

/* hdl/rf_data_pkg.sv */
`include "rf_consts.svh"

package rf_data_pkg;

    typedef logic [`RF_DATA_WIDTH-1:0] reg_data_t;
    typedef logic [`RF_ADDR_WIDTH-1:0] reg_addr_t;

    // Bit 0 low byte, bit 1 high byte, bit 2 upper half
    typedef logic [2:0] section_mask_t;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_word  = 2'd1,
        size_dword = 2'd2,
        size_none  = 2'd3
    } access_size_t;

    typedef struct packed {
        reg_addr_t     idx;
        section_mask_t mask;
    } section_sel_t;

    // Byte addresses 4 to 7 name the high byte of registers 0 to 3
    function automatic section_sel_t section_mask(reg_addr_t addr, access_size_t size);
        section_sel_t sel;
        sel.idx = addr;
        sel.mask = 3'b000;
        case (size)
            size_byte: begin
                sel.idx = {1'b0, addr[1:0]};
                sel.mask = addr[2] ? 3'b010 : 3'b001;
            end
            size_word:  sel.mask = 3'b011;
            size_dword: sel.mask = 3'b111;
            default:    sel.mask = 3'b000;
        endcase
        return sel;
    endfunction

endpackage

/* hdl/rf_ifs.sv */
`timescale 1ns/1ns

interface gpr_write_if;
    logic                      en;
    rf_data_pkg::reg_addr_t    addr;
    rf_data_pkg::access_size_t size;
    rf_data_pkg::reg_data_t    data;

    modport source (
        output en,
        output addr,
        output size,
        output data
    );

    modport sink (
        input en,
        input addr,
        input size,
        input data
    );
endinterface

interface tag_claim_if;
    logic                      en;
    rf_data_pkg::reg_addr_t    addr;
    rf_data_pkg::access_size_t size;
    rf_tag_pkg::tag_t          tag;

    modport source (
        output en,
        output addr,
        output size,
        output tag
    );

    modport sink (
        input en,
        input addr,
        input size,
        input tag
    );
endinterface

/* hdl/rf_tag_pkg.sv */
`include "rf_consts.svh"

package rf_tag_pkg;

    typedef logic [`RF_TAG_WIDTH-1:0] tag_t;

    // Index 0 low byte, 1 high byte, 2 upper half
    typedef tag_t [2:0] tag_set_t;

endpackage

/* hdl/tag_tracker.sv */
`timescale 1ns/1ns
`include "rf_consts.svh"

module tag_tracker (
    input  logic                      clk,
    input  logic                      reset,
    tag_claim_if.sink                 claim,
    input  logic                      broadcast_en,
    input  rf_tag_pkg::tag_t          broadcast_tag,
    input  logic                      flush,
    input  rf_data_pkg::reg_addr_t    rd_addr,
    input  rf_data_pkg::access_size_t rd_size,
    output logic                      rd_busy,
    output rf_tag_pkg::tag_t          rd_tag
);

    rf_tag_pkg::tag_set_t       tag_q   [`RF_NUM_REGS];
    rf_data_pkg::section_mask_t valid_q [`RF_NUM_REGS];

    rf_data_pkg::section_sel_t  claim_sel;
    rf_data_pkg::section_sel_t  rd_sel;
    rf_tag_pkg::tag_set_t       rd_tags;
    rf_data_pkg::section_mask_t rd_valid;

    assign claim_sel = rf_data_pkg::section_mask(claim.addr, claim.size);

    // Flush beats claim, and claim beats a broadcast on the same section
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `RF_NUM_REGS; r++) begin
                tag_q[r]   <= '0;
                valid_q[r] <= '0;
            end
        end else begin
            for (int r = 0; r < `RF_NUM_REGS; r++) begin
                for (int s = 0; s < 3; s++) begin
                    if (flush) begin
                        valid_q[r][s] <= 1'b0;
                    end else if (claim.en && claim_sel.idx == r && claim_sel.mask[s]) begin
                        tag_q[r][s]   <= claim.tag;
                        valid_q[r][s] <= 1'b1;
                    end else if (broadcast_en && valid_q[r][s]
                                 && tag_q[r][s] == broadcast_tag) begin
                        valid_q[r][s] <= 1'b0;
                    end
                end
            end
        end
    end

    assign rd_sel   = rf_data_pkg::section_mask(rd_addr, rd_size);
    assign rd_tags  = tag_q[rd_sel.idx];
    assign rd_valid = valid_q[rd_sel.idx];

    assign rd_busy = |(rd_valid & rd_sel.mask);

    // Tag of the section holding the least significant byte of the read
    always_comb begin
        if (rd_sel.mask[0]) begin
            rd_tag = rd_tags[0];
        end else if (rd_sel.mask[1]) begin
            rd_tag = rd_tags[1];
        end else if (rd_sel.mask[2]) begin
            rd_tag = rd_tags[2];
        end else begin
            rd_tag = '0;
        end
    end

    // Nothing can be pending right after a flush, whatever the read address
    busy_clear_after_flush: assert property (
        @(posedge clk) disable iff (reset)
        flush |=> !rd_busy
    );

endmodule

/* tb.f */
+incdir+hdl
hdl/rf_data_pkg.sv
hdl/rf_tag_pkg.sv
hdl/rf_ifs.sv
hdl/gpr_bank.sv
hdl/gpr_read_format.sv
hdl/tag_tracker.sv
hdl/regfile_top.sv
tb/regfile_tb.sv

/* tb/regfile_tb.sv */
`timescale 1ns/1ns

module regfile_tb;

    logic                      clk;
    logic                      reset;
    logic                      wr_en;
    rf_data_pkg::reg_addr_t    wr_addr;
    rf_data_pkg::access_size_t wr_size;
    rf_data_pkg::reg_data_t    wr_data;
    logic                      claim_en;
    rf_data_pkg::reg_addr_t    claim_addr;
    rf_data_pkg::access_size_t claim_size;
    rf_tag_pkg::tag_t          claim_tag;
    logic                      broadcast_en;
    rf_tag_pkg::tag_t          broadcast_tag;
    logic                      flush;
    rf_data_pkg::reg_addr_t    rd_addr;
    rf_data_pkg::access_size_t rd_size;
    rf_data_pkg::reg_data_t    rd_data;
    logic                      rd_busy;
    rf_tag_pkg::tag_t          rd_tag;

    integer seed;

    regfile_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "read output differs from expected value");
        end
    endtask

    // Inputs change 10 ns after the rising edge
    task automatic drive_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic write_reg(input logic [31:0] a, input logic [31:0] s, input logic [31:0] d);
        drive_slot();
        wr_en   = 1'b1;
        wr_addr = a[2:0];
        wr_size = rf_data_pkg::access_size_t'(s[1:0]);
        wr_data = d;
        drive_slot();
        wr_en = 1'b0;
    endtask

    task automatic claim_with_broadcast(input logic [31:0] a, input logic [31:0] s,
                                        input logic [31:0] t, input logic b_en,
                                        input logic [31:0] bt);
        drive_slot();
        claim_en      = 1'b1;
        claim_addr    = a[2:0];
        claim_size    = rf_data_pkg::access_size_t'(s[1:0]);
        claim_tag     = t[6:0];
        broadcast_en  = b_en;
        broadcast_tag = bt[6:0];
        drive_slot();
        claim_en     = 1'b0;
        broadcast_en = 1'b0;
    endtask

    task automatic broadcast_result(input logic [31:0] bt);
        drive_slot();
        broadcast_en  = 1'b1;
        broadcast_tag = bt[6:0];
        drive_slot();
        broadcast_en = 1'b0;
    endtask

    task automatic flush_all();
        drive_slot();
        flush = 1'b1;
        drive_slot();
        flush = 1'b0;
    endtask

    task automatic read_and_check(input logic [31:0] a, input logic [31:0] s,
                                  input logic [31:0] d, input logic [31:0] b,
                                  input logic [31:0] t);
        drive_slot();
        rd_addr = a[2:0];
        rd_size = rf_data_pkg::access_size_t'(s[1:0]);
        #20;
        check_value("rd_data", rd_data, d);
        check_value("rd_busy", {31'b0, rd_busy}, b);
        check_value("rd_tag", {25'b0, rd_tag}, t);
    endtask

    // Dword write of a random value, then dword and word reads of it
    task automatic random_fill(input logic [31:0] a);
        logic [31:0] val;
        val = $random(seed);
        write_reg(a, 2, val);
        drive_slot();
        rd_addr = a[2:0];
        rd_size = rf_data_pkg::size_dword;
        #20;
        check_value("rd_data", rd_data, val);
        rd_size = rf_data_pkg::size_word;
        #20;
        check_value("rd_data", rd_data, {{16{val[15]}}, val[15:0]});
    endtask

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;
    end

    initial begin
        integer fd;
        integer code;
        integer cycles;
        logic [7:0] op;
        logic [8*128-1:0] line;
        logic [31:0] a, s, d, b, t;
        logic done;
        seed = 56;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_size = rf_data_pkg::size_none;
        wr_data = '0;
        claim_en = 1'b0;
        claim_addr = '0;
        claim_size = rf_data_pkg::size_none;
        claim_tag = '0;
        broadcast_en = 1'b0;
        broadcast_tag = '0;
        flush = 1'b0;
        rd_addr = '0;
        rd_size = rf_data_pkg::size_dword;
        cycles = 0;
        // Reset may still be unknown here at time zero
        while (reset !== 1'b0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("TEST FAILED");
            $fatal(1, "Reset was not released within 20 cycles");
        end
        fd = $fopen("tb/regfile_testdata.txt", "r");
        if (fd == 0) begin
            $display("TEST FAILED");
            $fatal(1, "Could not open the stimulus file tb/regfile_testdata.txt");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                code = $fgets(line, fd);
            end else if (op == "w") begin
                code = $fscanf(fd, "%h %h %h", a, s, d);
                write_reg(a, s, d);
            end else if (op == "c") begin
                code = $fscanf(fd, "%h %h %h", a, s, t);
                claim_with_broadcast(a, s, t, 1'b0, 0);
            end else if (op == "k") begin
                code = $fscanf(fd, "%h %h %h %h", a, s, t, d);
                claim_with_broadcast(a, s, t, 1'b1, d);
            end else if (op == "b") begin
                code = $fscanf(fd, "%h", t);
                broadcast_result(t);
            end else if (op == "f") begin
                flush_all();
            end else if (op == "r") begin
                code = $fscanf(fd, "%h %h %h %h %h", a, s, d, b, t);
                read_and_check(a, s, d, b, t);
            end else if (op == "x") begin
                code = $fscanf(fd, "%h", a);
                random_fill(a);
            end else begin
                $display("TEST FAILED");
                $fatal(1, "Unknown operation code in the stimulus file");
            end
        end
        $fclose(fd);
        $display("TEST OK");
        $finish;
    end

endmodule

/* tb/regfile_testdata.txt */
# Sizes: 0 byte, 1 word, 2 dword. All numbers hex. w addr size data, c addr size tag,
# k addr size tag btag (claim and broadcast together), b tag, f, r addr size data busy tag
r 0 2 00000000 0 00
r 7 2 00000000 0 00
w 1 2 12345678
w 5 0 000000a5
r 1 2 1234a578 0 00
r 1 1 ffffa578 0 00
r 5 0 ffffffa5 0 00
r 1 0 00000078 0 00
w 2 2 8000c0f1
w 6 0 00000033
r 2 0 fffffff1 0 00
r 2 2 800033f1 0 00
c 3 1 15
r 3 2 00000000 1 15
r 7 0 00000000 1 15
w 3 2 aabbccdd
w 7 0 00000011
r 3 2 aabb11dd 1 15
b 22
r 3 2 aabb11dd 1 15
b 15
r 3 2 aabb11dd 0 15
c 4 2 30
k 4 2 31 30
r 4 2 00000000 1 31
c 0 0 41
c 6 0 42
f
r 0 2 00000000 0 41
r 6 0 00000033 0 42
r 4 2 00000000 0 31
x 5
x 7
